// File: Bender.yml
package:
  name: vram

sources:
  # Package first, then the blocks, then the top level.
  - verilog/vram_pkg.sv
  - verilog/vram_mem.sv
  - verilog/vram_row_shifter.sv
  - verilog/vram_row_fetch.sv
  - verilog/vram.sv

  - target: test
    files:
      - dv/vram_checker.sv
      - dv/vram_tb.sv

// File: dv/vram_checker.sv
`default_nettype none

module vram_checker (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         wr,
  input  wire vram_pkg::pixel_addr_t  wr_addr,
  input  wire vram_pkg::pixel_t       wr_data,
  input  wire                         rd,
  input  wire vram_pkg::row_addr_t    rd_row,
  input  wire vram_pkg::row_t         row_data,
  input  wire                         row_valid,
  input  wire                         busy,
  output int unsigned                 error_count,
  output int unsigned                 rows_compared
);

  timeunit 1ns;
  timeprecision 1ps;

  import vram_pkg::*;

  // One byte per pixel indexed by {row, column}.
  pixel_t frame [ROWS*COLS] = '{default: '0};

  row_t        exp_row;
  logic        exp_valid;
  logic        exp_busy;
  logic        after_reset;
  logic        new_row;
  int unsigned fetch_age;  // Counts edges since the accepting edge and stays 0 while idle.

  function automatic row_t model_row(input row_addr_t row);
    row_t        r;
    int unsigned c;
    for (c = 0; c < COLS; c++) begin
      r[c*PIXEL_W +: PIXEL_W] = frame[{row, COL_ADDR_W'(c)}];
    end
    return r;
  endfunction

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s at %0t: expected %h, actual %h", name, $time, expected, actual);
      error_count++;
    end
  endtask

  // Reports the first column that differs.
  task automatic check_row(input row_t expected, input row_t actual);
    int unsigned c;
    if (actual !== expected) begin
      c = 0;
      while (c < COLS - 1 &&
             actual[c*PIXEL_W +: PIXEL_W] === expected[c*PIXEL_W +: PIXEL_W]) begin
        c++;
      end
      $display("FAILED row_data column %0d at %0t: expected %h, actual %h", c, $time,
               expected[c*PIXEL_W +: PIXEL_W], actual[c*PIXEL_W +: PIXEL_W]);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      fetch_age     = 0;
      exp_valid     = 1'b0;
      exp_row       = '0;
      after_reset   = 1'b1;
      new_row       = 1'b0;
      error_count   = 0;
      rows_compared = 0;
    end else begin
      exp_busy = (fetch_age != 0);
      check_flag("busy", exp_busy, busy);
      check_flag("row_valid", exp_valid, row_valid);
      if (exp_valid || after_reset) begin
        check_row(exp_row, row_data);  // Zero right after reset.
      end
      if (new_row) begin
        rows_compared++;
        new_row = 1'b0;
      end
      after_reset = 1'b0;

      if (fetch_age != 0) begin
        // Strobes seen here are dropped by the DUT.
        if (fetch_age == FETCH_CYCLES - 1) begin
          fetch_age = 0;
          exp_valid = 1'b1;
          new_row   = 1'b1;
        end else begin
          fetch_age++;
        end
      end else if (wr) begin
        frame[wr_addr] = wr_data;  // Write wins over a read on the same edge.
        exp_valid      = 1'b0;
      end else if (rd) begin
        exp_row   = model_row(rd_row);
        exp_valid = 1'b0;
        fetch_age = 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/vram_tb.sv
`default_nettype none

module vram_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import vram_pkg::*;

  localparam int unsigned RESET_CYCLES  = 8;
  localparam int unsigned RANDOM_CYCLES = 2000;
  localparam int unsigned FRAME_PIXELS  = ROWS * COLS;
  localparam int unsigned FETCH_WAIT    = FETCH_CYCLES + 4;

  // Reset, the frame fill, one fetch of 19 cycles per row and the random mix
  // take about 7400 cycles, and the directed cases a few hundred more.
  localparam int unsigned TIMEOUT_CYCLES = 12000;

  logic        clk = 1'b0;
  logic        rst;
  logic        wr;
  pixel_addr_t wr_addr;
  pixel_t      wr_data;
  logic        rd;
  row_addr_t   rd_row;
  row_t        row_data;
  logic        row_valid;
  logic        busy;

  int unsigned value_errors;
  int unsigned rows_compared;
  int unsigned other_errors = 0;
  int unsigned rows_fetched = 0;
  int unsigned cycle_count  = 0;
  logic [31:0] lfsr_state   = 32'h5e79f318;

  always #10 clk = ~clk;

  vram i_dut (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd        (rd),
    .rd_row    (rd_row),
    .row_data  (row_data),
    .row_valid (row_valid),
    .busy      (busy)
  );

  vram_checker i_checker (
    .clk           (clk),
    .rst           (rst),
    .wr            (wr),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd            (rd),
    .rd_row        (rd_row),
    .row_data      (row_data),
    .row_valid     (row_valid),
    .busy          (busy),
    .error_count   (value_errors),
    .rows_compared (rows_compared)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h80200003;
    end
    return next;
  endfunction

  task automatic random_bits(input int unsigned width, output logic [31:0] value);
    int unsigned i;
    value = '0;
    for (i = 0; i < width; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic drive_cycle(input logic wr_en, input pixel_addr_t addr, input pixel_t data,
                             input logic rd_en, input row_addr_t row);
    @(posedge clk);
    wr      <= wr_en;
    wr_addr <= addr;
    wr_data <= data;
    rd      <= rd_en;
    rd_row  <= row;
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic write_pixel(input pixel_addr_t addr, input pixel_t data);
    drive_cycle(1'b1, addr, data, 1'b0, '0);
  endtask

  task automatic request_row(input row_addr_t row);
    drive_cycle(1'b0, '0, '0, 1'b1, row);
  endtask

  task automatic wait_idle();
    idle_cycle();
    @(negedge clk);
    while (busy) begin
      idle_cycle();
      @(negedge clk);
    end
  endtask

  // Called right after a request strobe has been driven.
  task automatic wait_row_valid();
    int unsigned waited;
    waited = 0;
    idle_cycle();
    @(negedge clk);
    while (!row_valid && waited < FETCH_WAIT) begin
      idle_cycle();
      @(negedge clk);
      waited++;
    end
    if (row_valid) begin
      rows_fetched++;
    end else begin
      $display("Error: row_valid did not rise within %0d cycles of a row request.",
               FETCH_WAIT);
      other_errors++;
    end
  endtask

  task automatic fetch_row(input row_addr_t row);
    wait_idle();
    request_row(row);
    wait_row_valid();
  endtask

  task automatic fill_frame();
    logic [31:0] data;
    int unsigned addr;
    for (addr = 0; addr < FRAME_PIXELS; addr++) begin
      random_bits(PIXEL_W, data);
      write_pixel(pixel_addr_t'(addr), pixel_t'(data));
    end
    idle_cycle();
  endtask

  task automatic check_drops();
    logic [31:0] bits;
    int unsigned i;
    wait_idle();
    request_row(row_addr_t'(5));
    idle_cycle();
    // Writes into the row in flight and reads of other rows, all while busy.
    for (i = 0; i < 12; i++) begin
      random_bits(PIXEL_W, bits);
      drive_cycle(1'b1, {row_addr_t'(5), COL_ADDR_W'(i)}, pixel_t'(bits), i[0],
                  row_addr_t'(i));
    end
    wait_row_valid();
    repeat (3) idle_cycle();
    random_bits(PIXEL_W, bits);
    drive_cycle(1'b1, {row_addr_t'(5), COL_ADDR_W'(3)}, pixel_t'(bits), 1'b1, row_addr_t'(5));
    idle_cycle();
    @(negedge clk);
    if (busy) begin
      $display("Error: a read issued together with a write started a fetch.");
      other_errors++;
    end
    fetch_row(row_addr_t'(5));  // Must show the pixel from the combined strobe.
  endtask

  task automatic check_hold_and_clear();
    logic [31:0] bits;
    fetch_row(row_addr_t'(9));
    repeat (25) idle_cycle();
    random_bits(PIXEL_W, bits);
    write_pixel({row_addr_t'(9), COL_ADDR_W'(17)}, pixel_t'(bits));
    repeat (5) idle_cycle();
    fetch_row(row_addr_t'(9));
    repeat (10) idle_cycle();
    fetch_row(row_addr_t'(10));
    // A read on the edge right after a write to the same row.
    wait_idle();
    random_bits(PIXEL_W, bits);
    write_pixel({row_addr_t'(33), COL_ADDR_W'(62)}, pixel_t'(bits));
    request_row(row_addr_t'(33));
    wait_row_valid();
  endtask

  task automatic random_mix();
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    int unsigned i;
    for (i = 0; i < RANDOM_CYCLES; i++) begin
      random_bits(3, op);
      random_bits(ROW_ADDR_W + COL_ADDR_W, addr);
      random_bits(PIXEL_W, data);
      case (op[2:0])
        3'd0, 3'd1: idle_cycle();
        3'd2, 3'd3, 3'd4: write_pixel(pixel_addr_t'(addr), pixel_t'(data));
        3'd5: request_row(row_addr_t'(addr[11:6]));
        3'd6: drive_cycle(1'b1, pixel_addr_t'(addr), pixel_t'(data), 1'b1,
                          row_addr_t'(addr[11:6]));
        default: begin
          write_pixel(pixel_addr_t'(addr), pixel_t'(data));
          request_row(row_addr_t'(addr[11:6]));
          i++;
        end
      endcase
    end
  endtask

  initial begin
    int unsigned row;
    rst     = 1'b1;
    wr      = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd      = 1'b0;
    rd_row  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    repeat (4) idle_cycle();

    fill_frame();
    for (row = 0; row < ROWS; row++) begin
      fetch_row(row_addr_t'(row));
    end
    check_drops();
    check_hold_and_clear();
    random_mix();
    wait_idle();
    repeat (4) idle_cycle();

    if (rows_compared < rows_fetched) begin
      $display("Error: the checker compared %0d rows but %0d were fetched.",
               rows_compared, rows_fetched);
      other_errors++;
    end
    $display("Errors: %0d value mismatches, %0d other failures, %0d rows compared.",
             value_errors, other_errors, rows_compared);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/vram.sv
`default_nettype none

module vram (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         wr,
  input  wire vram_pkg::pixel_addr_t  wr_addr,
  input  wire vram_pkg::pixel_t       wr_data,
  input  wire                         rd,
  input  wire vram_pkg::row_addr_t    rd_row,
  output vram_pkg::row_t              row_data,
  output logic                        row_valid,
  output logic                        busy
);

  import vram_pkg::*;

  logic       mem_we;
  logic       mem_re;
  word_addr_t mem_rd_addr;
  mem_word_t  mem_rd_data;
  logic       shift_load;

  // Command handling and the read sequence.
  vram_row_fetch i_row_fetch (
    .clk         (clk),
    .rst         (rst),
    .wr          (wr),
    .rd          (rd),
    .rd_row      (rd_row),
    .mem_we      (mem_we),
    .mem_re      (mem_re),
    .mem_rd_addr (mem_rd_addr),
    .shift_load  (shift_load),
    .busy        (busy),
    .row_valid   (row_valid)
  );

  // Write address and data come straight from the ports.
  vram_mem i_mem (
    .clk     (clk),
    .we      (mem_we),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .re      (mem_re),
    .rd_addr (mem_rd_addr),
    .rd_data (mem_rd_data)
  );

  vram_row_shifter i_row_shifter (
    .clk  (clk),
    .rst  (rst),
    .load (shift_load),
    .word (mem_rd_data),
    .row  (row_data)
  );

endmodule

`default_nettype wire

// File: verilog/vram_mem.sv
`default_nettype none

module vram_mem (
  input  wire                         clk,
  input  wire                         we,
  input  wire vram_pkg::pixel_addr_t  wr_addr,
  input  wire vram_pkg::pixel_t       wr_data,
  input  wire                         re,
  input  wire vram_pkg::word_addr_t   rd_addr,
  output vram_pkg::mem_word_t         rd_data
);

  import vram_pkg::*;

  // Frame store starts out black.
  mem_word_t mem [MEM_WORDS] = '{default: '0};

  word_addr_t wr_word;
  lane_t      wr_lane;

  // Column bits 5:2 pick the word, bits 1:0 the byte lane inside it.
  assign wr_word = wr_addr[ROW_ADDR_W+COL_ADDR_W-1:LANE_W];
  assign wr_lane = wr_addr[LANE_W-1:0];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_word][wr_lane*PIXEL_W +: PIXEL_W] <= wr_data;  // Only the addressed pixel changes.
    end
  end

  // Registered read with one cycle of latency.
  always_ff @(posedge clk) begin
    if (re) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: verilog/vram_pkg.sv
`default_nettype none

package vram_pkg;

  // Frame format.
  localparam int unsigned PIXEL_W    = 8;
  localparam int unsigned ROW_ADDR_W = 6;
  localparam int unsigned COL_ADDR_W = 6;
  localparam int unsigned ROWS       = 1 << ROW_ADDR_W;
  localparam int unsigned COLS       = 1 << COL_ADDR_W;

  // Memory organisation with four pixels per word.
  localparam int unsigned WORD_W          = 32;
  localparam int unsigned PIXELS_PER_WORD = WORD_W / PIXEL_W;
  localparam int unsigned LANE_W          = $clog2(PIXELS_PER_WORD);
  localparam int unsigned WORD_IDX_W      = COL_ADDR_W - LANE_W;
  localparam int unsigned WORDS_PER_ROW   = COLS / PIXELS_PER_WORD;
  localparam int unsigned WORD_ADDR_W     = ROW_ADDR_W + WORD_IDX_W;
  localparam int unsigned MEM_WORDS       = ROWS * WORDS_PER_ROW;
  localparam int unsigned ROW_W           = COLS * PIXEL_W;

  // Clock cycles from the accepting edge to row_valid.
  localparam int unsigned FETCH_CYCLES = WORDS_PER_ROW + 2;

  typedef logic [PIXEL_W-1:0]               pixel_t;
  typedef logic [ROW_ADDR_W+COL_ADDR_W-1:0] pixel_addr_t;  // {row, column}
  typedef logic [ROW_ADDR_W-1:0]            row_addr_t;
  typedef logic [WORD_ADDR_W-1:0]           word_addr_t;   // {row, word in row}
  typedef logic [WORD_IDX_W-1:0]            word_idx_t;
  typedef logic [LANE_W-1:0]                lane_t;
  typedef logic [WORD_W-1:0]                mem_word_t;    // Lowest column in bits 7:0.
  typedef logic [ROW_W-1:0]                 row_t;         // Column c in bits 8c+7:8c.

  typedef enum logic [1:0] {
    IDLE,
    READING,
    DRAINING
  } fetch_state_t;

endpackage

`default_nettype wire

// File: verilog/vram_row_fetch.sv
`default_nettype none

module vram_row_fetch (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         wr,
  input  wire                         rd,
  input  wire vram_pkg::row_addr_t    rd_row,
  output logic                        mem_we,
  output logic                        mem_re,
  output vram_pkg::word_addr_t        mem_rd_addr,
  output logic                        shift_load,
  output logic                        busy,
  output logic                        row_valid
);

  import vram_pkg::*;

  fetch_state_t state;
  row_addr_t    row_q;
  word_idx_t    word_cnt;

  logic idle;
  logic wr_accept;
  logic rd_accept;

  assign idle = (state == IDLE);

  // Commands only count while idle. A write beats a read on the same edge.
  assign wr_accept = wr & idle;
  assign rd_accept = rd & ~wr & idle;

  // The write lands in memory at the accepting edge itself.
  assign mem_we = wr_accept;
  assign busy   = ~idle;

  // Word 0 is issued from idle, words 1 to 15 from reading. Draining covers
  // the memory latency and the last shift, two cycles in all.
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      word_cnt   <= '0;
      mem_re     <= 1'b0;
      shift_load <= 1'b0;
      row_valid  <= 1'b0;
    end else begin
      shift_load <= mem_re;  // Read data shows up one cycle after mem_re.
      case (state)
        IDLE: begin
          mem_re <= rd_accept;
          if (wr_accept || rd_accept) begin
            row_valid <= 1'b0;  // Any accepted command retires the held row.
          end
          if (rd_accept) begin
            state    <= READING;
            word_cnt <= word_idx_t'(1);
          end
        end
        READING: begin
          mem_re   <= 1'b1;
          word_cnt <= word_cnt + 1'b1;
          if (word_cnt == word_idx_t'(WORDS_PER_ROW - 1)) begin
            state <= DRAINING;  // Counter wraps to 0 here.
          end
        end
        DRAINING: begin
          mem_re   <= 1'b0;
          word_cnt <= word_cnt + 1'b1;
          if (word_cnt == word_idx_t'(1)) begin
            state     <= IDLE;
            row_valid <= 1'b1;  // Word 15 is shifted in on this same edge.
          end
        end
        default: begin
          state  <= IDLE;
          mem_re <= 1'b0;
        end
      endcase
    end
  end

  // The row is latched on acceptance and the read address steps through it.
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      row_q       <= rd_row;
      mem_rd_addr <= {rd_row, word_idx_t'(0)};
    end else if (state == READING) begin
      mem_rd_addr <= {row_q, word_cnt};
    end
  end

endmodule

`default_nettype wire

// File: verilog/vram_row_shifter.sv
`default_nettype none

module vram_row_shifter (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        load,
  input  wire vram_pkg::mem_word_t   word,
  output vram_pkg::row_t             row
);

  import vram_pkg::*;

  // Words arrive in ascending order. Each one enters at the top and the
  // older words move down, so word 0 ends up in bits 31:0 after the last load.
  always_ff @(posedge clk) begin
    if (rst) begin
      row <= '0;
    end else if (load) begin
      row <= {word, row[ROW_W-1:WORD_W]};  // Shift right by one word.
    end
  end

endmodule

`default_nettype wire

// File: vram.f
verilog/vram_pkg.sv
verilog/vram_mem.sv
verilog/vram_row_shifter.sv
verilog/vram_row_fetch.sv
verilog/vram.sv
dv/vram_checker.sv
dv/vram_tb.sv
